// File: la_settings.svh
// capture core build settings
// LA_WIDTH is the sample width, and the command argument is fixed at 32 bits,
// so this value must stay at 32
// LA_DEPTH is the buffer address width, so the buffer holds 2**LA_DEPTH samples

`ifndef LA_SETTINGS_SVH
`define LA_SETTINGS_SVH

// sample width in bits
`define LA_WIDTH 32

// buffer address width, 5 gives 32 entries
`define LA_DEPTH 5

`endif

// File: la_cmd_pkg.sv
// command opcodes and the argument views of the 40-bit command word
// bits 39:32 are the opcode and bits 31:0 are the argument
// only the stage 0 trigger commands exist, and metadata and ID are not decoded

package la_cmd_pkg;

  localparam logic [7:0] OPC_SFT_RST  = 8'h00;
  localparam logic [7:0] OPC_ARM      = 8'h01;
  localparam logic [7:0] OPC_SET_DIV  = 8'h80;
  localparam logic [7:0] OPC_SET_CNT  = 8'h81;
  localparam logic [7:0] OPC_SET_MASK = 8'hC0;
  localparam logic [7:0] OPC_SET_VAL  = 8'hC1;

  // divider view, low 24 bits only
  typedef struct packed {
    logic [7:0]  rsvd;
    logic [23:0] fdiv;   // sample every fdiv+1 clocks
  } la_div_arg_t;

  // counts view
  typedef struct packed {
    logic [15:0] read_cnt;   // words sent after capture
    logic [15:0] delay_cnt;  // samples written after trigger
  } la_cnt_arg_t;

  // one argument word, decoded by whichever block takes the command
  typedef union packed {
    la_div_arg_t div;
    la_cnt_arg_t cnt;
    logic [31:0] word;   // raw, for mask and value
  } la_cmd_arg_u;

endpackage

// File: la_cap_pkg.sv
// sample and capture state types
// sample width comes from LA_WIDTH in the settings header

`include "la_settings.svh"

package la_cap_pkg;

  typedef logic [`LA_WIDTH-1:0] la_sample_t;

  // capture controller phases
  typedef enum logic [1:0] {
    CAP_IDLE  = 2'd0,
    CAP_ARMED = 2'd1,   // ring writes until run
    CAP_POST  = 2'd2,   // counting post-trigger writes
    CAP_READ  = 2'd3    // newest-first readout
  } la_cap_state_e;

endpackage

// File: la_cmd_decoder.sv
// command decoder
// cmd_i must be stable in the exec cycle
// one pulse follows exec by one cycle, unknown opcodes give no pulse

`timescale 1ns/10ps

module la_cmd_decoder
  import la_cmd_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       exec_i,
  input  logic [7:0] opc_i,
  output logic       sft_rst_o,
  output logic       arm_o,
  output logic       set_div_o,
  output logic       set_cnt_o,
  output logic       set_mask_o,
  output logic       set_val_o
);

  logic [7:0] opc_q;
  logic       exec_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exec_q <= 1'b0;
    end else begin
      exec_q <= exec_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (exec_i) begin
      opc_q <= opc_i;  // held until the next exec
    end
  end

  // exec_q qualifies the held opcode for one cycle
  assign sft_rst_o  = exec_q && (opc_q == OPC_SFT_RST);
  assign arm_o      = exec_q && (opc_q == OPC_ARM);
  assign set_div_o  = exec_q && (opc_q == OPC_SET_DIV);
  assign set_cnt_o  = exec_q && (opc_q == OPC_SET_CNT);
  assign set_mask_o = exec_q && (opc_q == OPC_SET_MASK);
  assign set_val_o  = exec_q && (opc_q == OPC_SET_VAL);

endmodule

// File: la_sampler.sv
// input synchronizer and sample divider
// data_i may be asynchronous, it passes two flop stages first
// one strobe every fdiv+1 clocks, fdiv 0 samples every clock

`timescale 1ns/10ps

module la_sampler
  import la_cmd_pkg::*;
  import la_cap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sft_rst_i,
  input  logic        set_div_i,
  input  la_cmd_arg_u arg_i,
  input  la_sample_t  data_i,
  output la_sample_t  smpl_o,
  output logic        smpl_stb_o
);

  logic [23:0] fdiv_q;
  logic [23:0] cnt_q;
  la_sample_t  sync_q1;
  la_sample_t  sync_q2;

  // two-stage synchronizer
  always_ff @(posedge clk_i) begin
    sync_q1 <= data_i;
    sync_q2 <= sync_q1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fdiv_q     <= '0;
      cnt_q      <= '0;
      smpl_stb_o <= 1'b0;
    end else if (sft_rst_i) begin
      fdiv_q     <= '0;
      cnt_q      <= '0;
      smpl_stb_o <= 1'b0;
    end else if (set_div_i) begin
      fdiv_q     <= arg_i.div.fdiv;
      cnt_q      <= arg_i.div.fdiv;  // new period starts now
      smpl_stb_o <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q      <= fdiv_q;
      smpl_stb_o <= 1'b1;
    end else begin
      cnt_q      <= cnt_q - 24'd1;
      smpl_stb_o <= 1'b0;
    end
  end

  // sample register, loaded on every terminal count
  always_ff @(posedge clk_i) begin
    if (cnt_q == '0) begin
      smpl_o <= sync_q2;
    end
  end

endmodule

// File: la_trigger.sv
// single-stage mask and value trigger
// run_o is a level, it rises one cycle after the matching strobe
// run_o falls on arm or soft reset, mask 0 fires on the first strobe

`timescale 1ns/10ps

module la_trigger
  import la_cmd_pkg::*;
  import la_cap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        sft_rst_i,
  input  logic        arm_i,
  input  logic        set_mask_i,
  input  logic        set_val_i,
  input  logic        smpl_stb_i,
  input  la_cmd_arg_u arg_i,
  input  la_sample_t  smpl_i,
  output logic        run_o
);

  la_sample_t mask_q;
  la_sample_t val_q;
  logic       armed_q;
  logic       hit;

  assign hit = armed_q && smpl_stb_i && ((smpl_i & mask_q) == (val_q & mask_q));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask_q  <= '0;
      val_q   <= '0;
      armed_q <= 1'b0;
      run_o   <= 1'b0;
    end else if (sft_rst_i) begin
      mask_q  <= '0;
      val_q   <= '0;
      armed_q <= 1'b0;
      run_o   <= 1'b0;
    end else begin
      if (set_mask_i) begin
        mask_q <= arg_i.word;
      end
      if (set_val_i) begin
        val_q <= arg_i.word;
      end
      if (arm_i) begin
        armed_q <= 1'b1;
        run_o   <= 1'b0;
      end else if (hit) begin
        armed_q <= 1'b0;  // one shot per arm
        run_o   <= 1'b1;
      end
    end
  end

endmodule

// File: la_sample_ram.sv
// sample buffer, single port
// write is synchronous, read data appears one cycle after the address
// contents are undefined until a capture has written them

`timescale 1ns/10ps
`include "la_settings.svh"

module la_sample_ram
  import la_cap_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 we_i,
  input  logic [`LA_DEPTH-1:0] addr_i,
  input  la_sample_t           d_i,
  output la_sample_t           q_o
);

  la_sample_t mem_q [0:(1 << `LA_DEPTH)-1];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= d_i;
    end
    q_o <= mem_q[addr_i];  // old data on a same-address write
  end

endmodule

// File: la_capture_ctrl.sv
// ring-buffer capture and newest-first readout
// read_cnt must not exceed the buffer size nor the samples written since arm
// tx_stb_o waits for tx_rdy_i, the cycle of a strobe does not look at it
// one buffer read is in flight at a time

`timescale 1ns/10ps
`include "la_settings.svh"

module la_capture_ctrl
  import la_cmd_pkg::*;
  import la_cap_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 sft_rst_i,
  input  logic                 arm_i,
  input  logic                 set_cnt_i,
  input  logic                 run_i,
  input  logic                 smpl_stb_i,
  input  logic                 tx_rdy_i,
  input  la_cmd_arg_u          arg_i,
  input  la_sample_t           smpl_i,
  input  la_sample_t           ram_q_i,
  output logic                 ram_we_o,
  output logic [`LA_DEPTH-1:0] ram_addr_o,
  output la_sample_t           ram_d_o,
  output logic                 tx_stb_o,
  output la_sample_t           tx_o
);

  la_cap_state_e        state_q;
  logic [15:0]          read_q;
  logic [15:0]          delay_q;
  logic [15:0]          post_q;    // writes since trigger
  logic [15:0]          left_q;    // words still to send
  logic [`LA_DEPTH-1:0] ptr_q;     // write pointer, then read pointer
  logic                 rd_pend_q;
  logic                 hold_q;    // tx_o holds an unsent word
  logic                 capturing;
  logic                 post_done;

  assign capturing  = (state_q == CAP_ARMED) || (state_q == CAP_POST);
  assign post_done  = run_i && (post_q == delay_q);
  assign ram_we_o   = capturing && smpl_stb_i && !post_done;
  assign ram_addr_o = ptr_q;
  assign ram_d_o    = smpl_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= CAP_IDLE;
      read_q    <= '0;
      delay_q   <= '0;
      post_q    <= '0;
      left_q    <= '0;
      ptr_q     <= '0;
      rd_pend_q <= 1'b0;
      hold_q    <= 1'b0;
      tx_stb_o  <= 1'b0;
    end else if (sft_rst_i) begin
      state_q   <= CAP_IDLE;
      read_q    <= '0;
      delay_q   <= '0;
      post_q    <= '0;
      left_q    <= '0;
      ptr_q     <= '0;
      rd_pend_q <= 1'b0;
      hold_q    <= 1'b0;
      tx_stb_o  <= 1'b0;
    end else begin
      tx_stb_o <= 1'b0;
      if (set_cnt_i) begin
        read_q  <= arg_i.cnt.read_cnt;
        delay_q <= arg_i.cnt.delay_cnt;
      end
      if (arm_i) begin
        state_q   <= CAP_ARMED;
        post_q    <= '0;
        rd_pend_q <= 1'b0;
        hold_q    <= 1'b0;
      end else begin
        unique case (state_q)
          CAP_IDLE: ;
          CAP_ARMED, CAP_POST: begin
            if (ram_we_o) begin
              ptr_q <= ptr_q + 1'b1;
            end
            if (ram_we_o && run_i) begin
              post_q <= post_q + 16'd1;
            end
            if (post_done) begin
              state_q <= CAP_READ;
              ptr_q   <= ptr_q - 1'b1;  // last written entry
              left_q  <= read_q;
            end else if (run_i) begin
              state_q <= CAP_POST;
            end
          end
          CAP_READ: begin
            if (left_q == '0) begin
              state_q <= CAP_IDLE;
            end else if (!rd_pend_q && !hold_q) begin
              rd_pend_q <= 1'b1;  // ram samples ptr_q this edge
            end
            if (rd_pend_q) begin
              rd_pend_q <= 1'b0;
              hold_q    <= 1'b1;
              ptr_q     <= ptr_q - 1'b1;
            end
            // hold_q is always low in the strobe cycle
            if (hold_q && tx_rdy_i) begin
              tx_stb_o <= 1'b1;
              hold_q   <= 1'b0;
              left_q   <= left_q - 16'd1;
            end
          end
          default: state_q <= CAP_IDLE;
        endcase
      end
    end
  end

  // outgoing word, stable while held and during its strobe
  always_ff @(posedge clk_i) begin
    if (rd_pend_q) begin
      tx_o <= ram_q_i;
    end
  end

endmodule

// File: la_core.sv
// logic analyzer capture core
// cmd_i is opcode in 39:32 and argument in 31:0, hold it two cycles after exec
// the serial transmitter is outside, it drops tx_rdy_i while busy
// soft reset is a synchronous clear, rst_n_i is the only async reset

`timescale 1ns/10ps
`include "la_settings.svh"

module la_core
  import la_cmd_pkg::*;
  import la_cap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        exec_i,
  input  logic        tx_rdy_i,
  input  logic [39:0] cmd_i,
  input  la_sample_t  input_i,
  output logic        tx_stb_o,
  output la_sample_t  tx_o
);

  la_cmd_arg_u          arg;
  logic                 sft_rst;
  logic                 arm;
  logic                 set_div;
  logic                 set_cnt;
  logic                 set_mask;
  logic                 set_val;
  la_sample_t           smpl;
  logic                 smpl_stb;
  logic                 run;
  logic                 ram_we;
  logic [`LA_DEPTH-1:0] ram_addr;
  la_sample_t           ram_d;
  la_sample_t           ram_q;

  assign arg = cmd_i[31:0];

  la_cmd_decoder decoder_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .exec_i     (exec_i),
    .opc_i      (cmd_i[39:32]),
    .sft_rst_o  (sft_rst),
    .arm_o      (arm),
    .set_div_o  (set_div),
    .set_cnt_o  (set_cnt),
    .set_mask_o (set_mask),
    .set_val_o  (set_val)
  );

  la_sampler sampler_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sft_rst_i  (sft_rst),
    .set_div_i  (set_div),
    .arg_i      (arg),
    .data_i     (input_i),
    .smpl_o     (smpl),
    .smpl_stb_o (smpl_stb)
  );

  la_trigger trigger_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sft_rst_i  (sft_rst),
    .arm_i      (arm),
    .set_mask_i (set_mask),
    .set_val_i  (set_val),
    .smpl_stb_i (smpl_stb),
    .arg_i      (arg),
    .smpl_i     (smpl),
    .run_o      (run)
  );

  la_capture_ctrl capture_ctrl_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .sft_rst_i  (sft_rst),
    .arm_i      (arm),
    .set_cnt_i  (set_cnt),
    .run_i      (run),
    .smpl_stb_i (smpl_stb),
    .tx_rdy_i   (tx_rdy_i),
    .arg_i      (arg),
    .smpl_i     (smpl),
    .ram_q_i    (ram_q),
    .ram_we_o   (ram_we),
    .ram_addr_o (ram_addr),
    .ram_d_o    (ram_d),
    .tx_stb_o   (tx_stb_o),
    .tx_o       (tx_o)
  );

  la_sample_ram sample_ram_inst (
    .clk_i  (clk_i),
    .we_i   (ram_we),
    .addr_i (ram_addr),
    .d_i    (ram_d),
    .q_o    (ram_q)
  );

endmodule

// File: tb_la_core.sv
// directed testbench for the capture core
// input_i is a free-running counter, so captured words step by fdiv+1
// the transmitter model drops tx_rdy_i after every strobe for a fixed or random time
// the run stops at the first mismatch, and a watchdog bounds its length

`timescale 1ns/10ps

module tb_la_core
  import la_cmd_pkg::*;
  import la_cap_pkg::*;
();

  localparam int FIX_BUSY    = 3;
  localparam int MAX_BUSY    = 20;
  localparam int V_AHEAD     = 30;  // trigger value lead over the counter
  localparam int WINDOW      = 60;  // quiet time when no word may arrive
  localparam int IDLE_CYCLES = 50;

  logic        clk_i;
  logic        rst_n_i;
  logic        exec_i;
  logic        tx_rdy_i;
  logic [39:0] cmd_i;
  la_sample_t  input_i;
  logic        tx_stb_o;
  la_sample_t  tx_o;

  la_sample_t  rx_q[$];  // words taken by the transmitter model
  bit          rand_busy = 1'b0;
  logic [31:0] rnd_state = 32'h7955;

  la_core la_core_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .exec_i   (exec_i),
    .tx_rdy_i (tx_rdy_i),
    .cmd_i    (cmd_i),
    .input_i  (input_i),
    .tx_stb_o (tx_stb_o),
    .tx_o     (tx_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // sample source, one step per clock
  initial begin
    input_i = '0;
    forever begin
      @(posedge clk_i);
      #1;
      input_i = input_i + 32'd1;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // transmitter model
  initial begin : tx_model
    int busy;
    tx_rdy_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      if (tx_stb_o) begin
        rx_q.push_back(tx_o);
        if (rand_busy) begin
          rnd_state = xorshift32(rnd_state);
          busy      = int'(rnd_state % 32'd21);  // 0 to MAX_BUSY
        end else begin
          busy = FIX_BUSY;
        end
        if (busy > 0) begin
          tx_rdy_i = 1'b0;
          repeat (busy) @(posedge clk_i);
          #1;
          tx_rdy_i = 1'b1;
        end
      end
    end
  end

  // cycles for one capture test: commands, sampling, readout, settle
  function automatic int capture_budget(input int rd, input int dly, input int fdiv,
                                        input int pre, input int busy_max);
    return 40 + (pre + dly + 8) * (fdiv + 1) + rd * (busy_max + 6) + 40;
  endfunction

  initial begin : watchdog
    int limit;
    limit = 3 + IDLE_CYCLES + 10;
    limit = limit + capture_budget(8, 8, 0, 0, FIX_BUSY);
    limit = limit + capture_budget(8, 8, 3, 0, FIX_BUSY);
    limit = limit + capture_budget(10, 5, 0, V_AHEAD, FIX_BUSY);
    limit = limit + 2 * WINDOW + 40 + capture_budget(6, 5, 0, 0, FIX_BUSY);
    limit = limit + capture_budget(8, 8, 0, 0, MAX_BUSY);
    limit = limit + limit / 4;
    repeat (limit) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d clock cycles", limit);
    report_failure();
  end

  task automatic report_failure();
    $display("Some tests failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_sample(input string sig, input la_sample_t exp, input la_sample_t act);
    if (act !== exp) begin
      $display("Error: %s expected 0x%h got 0x%h", sig, exp, act);
      report_failure();
    end
  endtask

  task automatic check_state(input string sig, input la_cap_state_e exp,
                             input la_cap_state_e act);
    if (act !== exp) begin
      $display("Error: %s expected 0x%h (%s) got 0x%h (%s)",
               sig, exp, exp.name(), act, act.name());
      report_failure();
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("%s: expected %0d words from the transmitter, but %0d arrived",
               what, exp, act);
      report_failure();
    end
  endtask

  task automatic send_cmd(input logic [7:0] opc, input la_cmd_arg_u arg);
    @(posedge clk_i);
    #1;
    cmd_i  = {opc, arg};
    exec_i = 1'b1;
    @(posedge clk_i);
    #1;
    exec_i = 1'b0;
    repeat (2) @(posedge clk_i);  // argument still valid at the decoded pulse
  endtask

  task automatic set_counts(input int rd, input int dly);
    la_cmd_arg_u a;
    a.cnt.read_cnt  = 16'(rd);
    a.cnt.delay_cnt = 16'(dly);
    send_cmd(OPC_SET_CNT, a);
  endtask

  // waits for n words, then makes sure no more follow
  task automatic wait_words(input string what, input int n);
    while (rx_q.size() < n) begin
      @(posedge clk_i);
    end
    repeat (20) @(posedge clk_i);
    check_count(what, n, rx_q.size());
    check_state("capture state", CAP_IDLE, la_core_inst.capture_ctrl_inst.state_q);
  endtask

  // newest first, so each word is one step below the one before
  task automatic check_steps(input la_sample_t step);
    int    i;
    string sig;
    for (i = 1; i < rx_q.size(); i++) begin
      sig = $sformatf("tx_o word %0d", i);
      check_sample(sig, rx_q[i-1] - step, rx_q[i]);
    end
  endtask

  task automatic test_reset_state();
    $display("test: reset state");
    check_state("capture state", CAP_IDLE, la_core_inst.capture_ctrl_inst.state_q);
    repeat (IDLE_CYCLES) @(posedge clk_i);
    check_count("reset state", 0, rx_q.size());
  endtask

  task automatic test_immediate_capture();
    $display("test: immediate capture");
    send_cmd(OPC_SET_DIV, '0);
    send_cmd(OPC_SET_MASK, '0);
    set_counts(8, 8);
    rx_q.delete();
    send_cmd(OPC_ARM, '0);
    wait_words("immediate capture", 8);
    check_steps(32'd1);
  endtask

  task automatic test_divider();
    $display("test: divider");
    send_cmd(OPC_SET_DIV, 32'd3);
    set_counts(8, 8);
    rx_q.delete();
    send_cmd(OPC_ARM, '0);
    wait_words("divider", 8);
    check_steps(32'd4);
  endtask

  task automatic test_value_trigger();
    la_sample_t v;
    int         i;
    string      sig;
    $display("test: value trigger");
    send_cmd(OPC_SET_DIV, '0);
    set_counts(10, 5);
    send_cmd(OPC_SET_MASK, 32'hFFFF_FFFF);
    v = input_i + 32'(V_AHEAD);
    send_cmd(OPC_SET_VAL, v);
    rx_q.delete();
    send_cmd(OPC_ARM, '0);
    wait_words("value trigger", 10);
    // word 5 is the trigger, 0 to 4 came after it
    for (i = 0; i < 10; i++) begin
      sig = $sformatf("tx_o word %0d", i);
      check_sample(sig, v + 32'd5 - la_sample_t'(i), rx_q[i]);
    end
  endtask

  task automatic test_soft_reset();
    $display("test: soft reset");
    send_cmd(OPC_SET_DIV, 32'd3);  // soft reset must bring it back to 0
    send_cmd(OPC_SET_MASK, 32'hFFFF_FFFF);
    send_cmd(OPC_SET_VAL, input_i - 32'd16);  // already passed
    rx_q.delete();
    send_cmd(OPC_ARM, '0);
    repeat (WINDOW) @(posedge clk_i);
    check_count("armed with no match", 0, rx_q.size());
    send_cmd(OPC_SFT_RST, '0);
    repeat (WINDOW) @(posedge clk_i);
    check_count("after soft reset", 0, rx_q.size());
    check_state("capture state", CAP_IDLE, la_core_inst.capture_ctrl_inst.state_q);
    set_counts(6, 5);  // trigger plus 5, all written since arm
    send_cmd(OPC_ARM, '0);
    wait_words("capture after soft reset", 6);
    check_steps(32'd1);  // divider cleared too
  endtask

  task automatic test_back_pressure();
    $display("test: back-pressure");
    rand_busy = 1'b1;
    set_counts(8, 8);
    rx_q.delete();
    send_cmd(OPC_ARM, '0);
    wait_words("back-pressure", 8);
    check_steps(32'd1);
    rand_busy = 1'b0;
  endtask

  initial begin
    rst_n_i = 1'b0;
    exec_i  = 1'b0;
    cmd_i   = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_reset_state();
    test_immediate_capture();
    test_divider();
    test_value_trigger();
    test_soft_reset();
    test_back_pressure();
    $display("All tests passed");
    $finish;
  end

endmodule

// File: files.f
+incdir+.
la_cmd_pkg.sv
la_cap_pkg.sv
la_cmd_decoder.sv
la_sampler.sv
la_trigger.sv
la_sample_ram.sv
la_capture_ctrl.sv
la_core.sv
tb_la_core.sv

// File: run.sh
#!/bin/sh
# builds and runs the capture core testbench with Verilator
# exit status is 0 only when the pass line shows up in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_la_core -Mdir obj_dir -f files.f \
  || { echo "build FAILED"; exit 1; }
out=$(./obj_dir/Vtb_la_core 2>&1)
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }
